// File: src/axi_slice_cfg.svh
// width and reset-sync settings for the axi register slice, pulled in by `include wherever needed
`ifndef AXI_SLICE_CFG_SVH
`define AXI_SLICE_CFG_SVH

// --------------------------------------------------
// axi4 bus widths on the memory side
// --------------------------------------------------
`define AXI_ADDR_W 64   // byte address bits
`define AXI_DATA_W 512  // one beat, a full cache line
`define AXI_ID_W   4    // engine cluster transaction id

// --------------------------------------------------
// slice control
// --------------------------------------------------
// rising edges that stage_rst_n stays low after arst_n releases
`define SLICE_SYNC_CYCLES 2

// largest number of bursts tracked per direction
`define SLICE_MAX_OUTSTANDING 16

`endif

// File: src/axi_slice_pkg.sv
// shared axi4 types for the register slice, imported by the slice modules and the testbench
`include "axi_slice_cfg.svh"

package axi_slice_pkg;

  // --------------------------------------------------
  // field types
  // --------------------------------------------------
  typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t; // byte address
  typedef logic [`AXI_DATA_W-1:0]   axi_data_t; // one data beat
  typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t; // one strobe per byte lane
  typedef logic [`AXI_ID_W-1:0]     axi_id_t;   // transaction id
  typedef logic [7:0]               axi_len_t;  // beats minus one
  typedef logic [1:0]               axi_resp_t; // okay, exokay, slverr, decerr

  // --------------------------------------------------
  // channel payloads
  // --------------------------------------------------
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    logic [2:0] size;   // log2 of bytes per beat
    logic [1:0] burst;  // fixed, incr, wrap
    logic       lock;
    logic [3:0] cache;  // memory type attributes
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
  } ar_chan_t;

  // write address carries the same fields as read address
  typedef ar_chan_t aw_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last; // final beat of the burst
  } w_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } r_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_chan_t;

  // --------------------------------------------------
  // bundles, split by driving side
  // --------------------------------------------------
  typedef struct packed {
    ar_chan_t ar;
    aw_chan_t aw;
    w_chan_t  w;
    logic     ar_valid;
    logic     aw_valid;
    logic     w_valid;
    logic     r_ready;
    logic     b_ready;
  } axi_req_t; // master to slave

  typedef struct packed {
    r_chan_t r;
    b_chan_t b;
    logic    ar_ready;
    logic    aw_ready;
    logic    w_ready;
    logic    r_valid;
    logic    b_valid;
  } axi_rsp_t; // slave to master

  // reset sequencing in the slice control
  typedef enum logic [1:0] {
    ST_RESET, // arst_n asserted
    ST_SYNC,  // counting release cycles
    ST_RUN    // stages out of reset
  } slice_state_e;

endpackage

// File: src/axi_skid_stage.sv
// two-entry valid/ready register stage for one axi channel, instantiated once per channel
module axi_skid_stage #(
  parameter int WIDTH = 8 // payload bits of the channel
) (
  input  logic             ap_clk,
  input  logic             stage_rst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  logic             accept;        // beat taken on the input side
  logic             main_load;     // main entry empty or draining this cycle
  logic             spare_valid;   // spare entry holds a stalled beat
  logic             spare_valid_d;
  logic             out_valid_d;
  logic [WIDTH-1:0] spare_data;    // beat caught while the output stalls

  assign accept    = in_valid & in_ready;
  assign main_load = ~out_valid | out_ready;

  // --------------------------------------------------
  // occupancy
  // --------------------------------------------------
  always_comb begin
    spare_valid_d = spare_valid;
    out_valid_d   = out_valid;
    if (main_load) begin
      spare_valid_d = 1'b0;                   // spare always drains first
      out_valid_d   = spare_valid | accept;
    end else if (accept) begin
      spare_valid_d = 1'b1;                   // output stalled, park the beat
    end
  end

  always_ff @(posedge ap_clk or negedge stage_rst_n) begin
    if (!stage_rst_n) begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
      in_ready    <= 1'b0;
    end else begin
      out_valid   <= out_valid_d;
      spare_valid <= spare_valid_d;
      in_ready    <= ~spare_valid_d;          // low only with both entries full
    end
  end

  // --------------------------------------------------
  // payload path
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (main_load) begin
      if (spare_valid) begin
        out_data <= spare_data;               // older beat goes out first
      end else if (accept) begin
        out_data <= in_data;
      end
    end
    if (accept && !main_load) begin
      spare_data <= in_data;
    end
  end

  // stalled beat must not change under the receiver
  a_out_stable: assert property (
    @(posedge ap_clk) disable iff (!stage_rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

  // with both entries full the offered beat has to wait unchanged
  a_hold_while_full: assert property (
    @(posedge ap_clk) disable iff (!stage_rst_n)
    out_valid && spare_valid && in_valid |=> in_valid && $stable(in_data)
  );

endmodule

// File: src/axi_slice_ctrl.sv
// reset release and outstanding-burst tracking for the register slice, one per slice top level
`include "axi_slice_cfg.svh"

module axi_slice_ctrl import axi_slice_pkg::*; (
  input  logic ap_clk,
  input  logic arst_n,
  input  logic ar_xfer,     // read address accepted from the engine
  input  logic r_last_xfer, // last read beat handed to the engine
  input  logic aw_xfer,     // write address accepted from the engine
  input  logic b_xfer,      // write response handed to the engine
  output logic stage_rst_n,
  output logic idle
);

  localparam int SYNC_LAST = `SLICE_SYNC_CYCLES - 1;
  localparam int SYNC_W    = $clog2(`SLICE_SYNC_CYCLES + 1);
  localparam int CNT_W     = $clog2(`SLICE_MAX_OUTSTANDING + 1);
  localparam int CNT_MAX   = `SLICE_MAX_OUTSTANDING;

  slice_state_e      state;
  logic [SYNC_W-1:0] sync_cnt; // edges seen since arst_n released
  logic [CNT_W-1:0]  rd_cnt;   // read bursts still owed data
  logic [CNT_W-1:0]  wr_cnt;   // write bursts still owed a response

  // --------------------------------------------------
  // reset release sequence
  // --------------------------------------------------
  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= ST_RESET;
      sync_cnt    <= '0;
      stage_rst_n <= 1'b0;                     // stages drop immediately
    end else begin
      case (state)
        ST_RESET: begin
          state    <= ST_SYNC;
          sync_cnt <= SYNC_W'(1);              // first edge after release
        end
        ST_SYNC: begin
          if (sync_cnt == SYNC_W'(SYNC_LAST)) begin
            state       <= ST_RUN;
            stage_rst_n <= 1'b1;
          end else begin
            sync_cnt <= sync_cnt + 1'b1;
          end
        end
        ST_RUN:  stage_rst_n <= 1'b1;          // stays here until next arst_n
        default: state <= ST_RESET;
      endcase
    end
  end

  // --------------------------------------------------
  // outstanding bursts
  // --------------------------------------------------
  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      if (ar_xfer && !r_last_xfer) rd_cnt <= rd_cnt + 1'b1;
      else if (!ar_xfer && r_last_xfer) rd_cnt <= rd_cnt - 1'b1;
      if (aw_xfer && !b_xfer) wr_cnt <= wr_cnt + 1'b1;
      else if (!aw_xfer && b_xfer) wr_cnt <= wr_cnt - 1'b1;
    end
  end

  assign idle = (rd_cnt == '0) && (wr_cnt == '0); // nothing in flight either way

  // a completion with nothing open means the top level miscounts its pulses
  a_rd_range: assert property (@(posedge ap_clk) disable iff (!arst_n)
    (r_last_xfer && !ar_xfer |-> rd_cnt != '0) and
    (ar_xfer && !r_last_xfer |-> rd_cnt < CNT_W'(CNT_MAX)));
  a_wr_range: assert property (@(posedge ap_clk) disable iff (!arst_n)
    (b_xfer && !aw_xfer |-> wr_cnt != '0) and
    (aw_xfer && !b_xfer |-> wr_cnt < CNT_W'(CNT_MAX)));

endmodule

// File: src/axi_register_slice_mid_end.sv
// axi4 register slice between the engine cluster and the memory controller, one stage per channel
module axi_register_slice_mid_end import axi_slice_pkg::*; (
  input  logic     ap_clk,
  input  logic     arst_n,
  input  axi_req_t s_req,  // from engine cluster
  output axi_rsp_t s_rsp,  // to engine cluster
  output axi_req_t m_req,  // to memory controller
  input  axi_rsp_t m_rsp,  // from memory controller
  output logic     idle
);

  // --------------------------------------------------
  // stage edge signals
  // --------------------------------------------------
  logic     stage_rst_n;           // released by u_ctrl after sync
  logic     ar_in_ready;
  logic     ar_out_valid;
  ar_chan_t ar_out;
  logic     aw_in_ready;
  logic     aw_out_valid;
  aw_chan_t aw_out;
  logic     w_in_ready;
  logic     w_out_valid;
  w_chan_t  w_out;
  logic     r_in_ready;
  logic     r_out_valid;
  r_chan_t  r_out;
  logic     b_in_ready;
  logic     b_out_valid;
  b_chan_t  b_out;
  logic     ar_xfer;
  logic     r_last_xfer;
  logic     aw_xfer;
  logic     b_xfer;

  // handshakes seen on the engine side
  assign ar_xfer     = s_req.ar_valid & ar_in_ready;
  assign aw_xfer     = s_req.aw_valid & aw_in_ready;
  assign r_last_xfer = r_out_valid & s_req.r_ready & r_out.last; // burst done
  assign b_xfer      = b_out_valid & s_req.b_ready;

  axi_slice_ctrl u_ctrl (
    .ap_clk      (ap_clk),
    .arst_n      (arst_n),
    .ar_xfer     (ar_xfer),
    .r_last_xfer (r_last_xfer),
    .aw_xfer     (aw_xfer),
    .b_xfer      (b_xfer),
    .stage_rst_n (stage_rst_n),
    .idle        (idle)
  );

  // --------------------------------------------------
  // forward stages, engine to memory
  // --------------------------------------------------
  axi_skid_stage #(.WIDTH($bits(ar_chan_t))) u_ar (
    .ap_clk(ap_clk), .stage_rst_n(stage_rst_n),
    .in_valid(s_req.ar_valid), .in_ready(ar_in_ready), .in_data(s_req.ar),
    .out_valid(ar_out_valid), .out_ready(m_rsp.ar_ready), .out_data(ar_out)
  );

  axi_skid_stage #(.WIDTH($bits(aw_chan_t))) u_aw (
    .ap_clk(ap_clk), .stage_rst_n(stage_rst_n),
    .in_valid(s_req.aw_valid), .in_ready(aw_in_ready), .in_data(s_req.aw),
    .out_valid(aw_out_valid), .out_ready(m_rsp.aw_ready), .out_data(aw_out)
  );

  axi_skid_stage #(.WIDTH($bits(w_chan_t))) u_w (
    .ap_clk(ap_clk), .stage_rst_n(stage_rst_n),
    .in_valid(s_req.w_valid), .in_ready(w_in_ready), .in_data(s_req.w),
    .out_valid(w_out_valid), .out_ready(m_rsp.w_ready), .out_data(w_out)
  );

  // --------------------------------------------------
  // backward stages, memory to engine
  // --------------------------------------------------
  axi_skid_stage #(.WIDTH($bits(r_chan_t))) u_r (
    .ap_clk(ap_clk), .stage_rst_n(stage_rst_n),
    .in_valid(m_rsp.r_valid), .in_ready(r_in_ready), .in_data(m_rsp.r),
    .out_valid(r_out_valid), .out_ready(s_req.r_ready), .out_data(r_out)
  );

  axi_skid_stage #(.WIDTH($bits(b_chan_t))) u_b (
    .ap_clk(ap_clk), .stage_rst_n(stage_rst_n),
    .in_valid(m_rsp.b_valid), .in_ready(b_in_ready), .in_data(m_rsp.b),
    .out_valid(b_out_valid), .out_ready(s_req.b_ready), .out_data(b_out)
  );

  // repack the stage outputs into the two bundles
  always_comb begin
    m_req.ar       = ar_out;
    m_req.aw       = aw_out;
    m_req.w        = w_out;
    m_req.ar_valid = ar_out_valid;
    m_req.aw_valid = aw_out_valid;
    m_req.w_valid  = w_out_valid;
    m_req.r_ready  = r_in_ready;   // registered, no path from s_req
    m_req.b_ready  = b_in_ready;
    s_rsp.r        = r_out;
    s_rsp.b        = b_out;
    s_rsp.ar_ready = ar_in_ready;
    s_rsp.aw_ready = aw_in_ready;
    s_rsp.w_ready  = w_in_ready;
    s_rsp.r_valid  = r_out_valid;
    s_rsp.b_valid  = b_out_valid;
  end

endmodule

// File: test/axi_slice_tb.sv
// self-checking testbench for the axi register slice, compile with tb.f and run top axi_slice_tb
`include "axi_slice_cfg.svh"

module axi_slice_tb import axi_slice_pkg::*; ();

  typedef struct packed {
    logic        wr;    // write burst, else read
    axi_id_t     id;
    axi_addr_t   addr;
    axi_len_t    len;
    logic [31:0] seed;  // data pattern key
    logic        stall; // random ready stalls on both sides
  } entry_t;

  localparam int N_ENTRY = 8;

  logic        ap_clk = 1'b0;
  logic        arst_n;
  axi_req_t    s_req;
  axi_rsp_t    s_rsp;
  axi_req_t    m_req;
  axi_rsp_t    m_rsp;
  logic        idle;
  entry_t      tbl [N_ENTRY];
  int          cur = 0;            // entry being applied
  int          cyc = 0;            // rising edges so far
  int          limit = 1000;
  int          errors = 0;
  int          checks = 0;
  int          sent = 0;           // beats handed into the slice
  int          rcvd = 0;           // beats taken out of the slice
  logic [31:0] rnd = 32'h0d700177;
  int          addr_xfer_cyc;      // edge of the engine-side address handshake
  int          w_first_cyc;
  ar_chan_t    r_ar = '0;          // burst the responder is serving
  int          r_idx = 256;        // past any len means no read data pending
  logic        r_fire = 1'b0;
  int          w_idx = 0;
  logic        w_done = 1'b0;
  logic        aw_got = 1'b0;
  axi_id_t     b_id;
  logic        b_pend = 1'b0;
  logic        b_fire = 1'b0;

  axi_register_slice_mid_end u_dut (
    .ap_clk(ap_clk), .arst_n(arst_n), .s_req(s_req), .s_rsp(s_rsp),
    .m_req(m_req), .m_rsp(m_rsp), .idle(idle)
  );

  initial begin
    forever #5 ap_clk = ~ap_clk;
  end

  always @(posedge ap_clk) begin
    cyc = cyc + 1;
    rnd = xorshift(rnd);               // new stall pattern each cycle
    if (cyc > limit) begin
      $display("Timeout: the slice did not finish the table within %0d cycles", limit);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic ready_roll(input int k, input logic en);
    return !(en && rnd[k] && rnd[k+8]); // low about one cycle in four
  endfunction

  // addr xor beat index xor seed on every 32-bit lane
  function automatic axi_data_t beat_data(input axi_addr_t addr, input int beat,
                                          input logic [31:0] seed);
    return {(`AXI_DATA_W/32){addr[31:0] ^ beat ^ seed}};
  endfunction

  // 64-byte incr bursts, qos follows the id
  function automatic ar_chan_t make_ax(input entry_t t);
    return {t.id, t.addr, t.len, 3'd6, 2'b01, 1'b0, 4'b0011, 3'b000, t.id, 4'h0};
  endfunction

  task automatic check_eq(input string name, input logic [1023:0] got,
                          input logic [1023:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_quiet(input logic rdy);
    check_eq("valids", {m_req.ar_valid, m_req.aw_valid, m_req.w_valid, s_rsp.r_valid,
                        s_rsp.b_valid}, 5'b0);
    check_eq("readies", {s_rsp.ar_ready, s_rsp.aw_ready, s_rsp.w_ready, m_req.r_ready,
                         m_req.b_ready}, {5{rdy}});
    check_eq("idle", idle, 1'b1);
  endtask

  // --------------------------------------------------
  // memory responder on the master-side ports
  // --------------------------------------------------
  always @(negedge ap_clk) begin
    entry_t t;
    t = tbl[cur];
    if (r_fire) r_idx = r_idx + 1;     // beat left at the last edge
    if (b_fire) b_pend = 1'b0;
    m_rsp.ar_ready = ready_roll(0, t.stall);
    m_rsp.aw_ready = ready_roll(1, t.stall);
    m_rsp.w_ready  = ready_roll(2, t.stall);
    m_rsp.r_valid  = r_idx <= int'(r_ar.len);
    m_rsp.r        = {r_ar.id, beat_data(r_ar.addr, r_idx, t.seed), 2'b00,
                      r_idx == int'(r_ar.len)};
    r_fire = m_rsp.r_valid && m_req.r_ready; // ready is a register, stable until the edge
    if (r_fire) sent++;
    m_rsp.b_valid  = b_pend;
    m_rsp.b        = {b_id, 2'b00};    // always okay
    b_fire = b_pend && m_req.b_ready;
    if (m_req.ar_valid && m_rsp.ar_ready) begin
      check_eq("m_req.ar", m_req.ar, make_ax(t));
      if (!t.stall) check_eq("ar latency", cyc, addr_xfer_cyc);
      r_ar  = m_req.ar;
      r_idx = 0;                       // data starts next cycle
    end
    if (m_req.aw_valid && m_rsp.aw_ready) begin
      check_eq("m_req.aw", m_req.aw, make_ax(t));
      if (!t.stall) check_eq("aw latency", cyc, addr_xfer_cyc);
      b_id   = m_req.aw.id;
      aw_got = 1'b1;
    end
    if (m_req.w_valid && m_rsp.w_ready) begin
      check_eq("m_req.w", m_req.w, {beat_data(t.addr, w_idx, t.seed),
                                    {(`AXI_DATA_W/8){1'b1}}, w_idx == int'(t.len)});
      if (!t.stall && m_req.w.last) check_eq("w burst cycles", cyc + 1 - w_first_cyc, t.len + 1);
      w_done = m_req.w.last;
      w_idx  = w_idx + 1;
      rcvd++;
    end
    if (aw_got && w_done && !b_pend) begin // response once address and all data are in
      b_pend = 1'b1;
      aw_got = 1'b0;
      w_done = 1'b0;
      w_idx  = 0;
    end
  end

  // --------------------------------------------------
  // engine-side driver
  // --------------------------------------------------
  task automatic send_addr(input entry_t t);
    if (t.wr) begin
      s_req.aw       = make_ax(t);
      s_req.aw_valid = 1'b1;
      while (!s_rsp.aw_ready) @(negedge ap_clk);
    end else begin
      s_req.ar       = make_ax(t);
      s_req.ar_valid = 1'b1;
      while (!s_rsp.ar_ready) @(negedge ap_clk);
    end
    addr_xfer_cyc = cyc + 1;           // handshake on the coming edge
    @(negedge ap_clk);
    s_req.ar_valid = 1'b0;
    s_req.aw_valid = 1'b0;
    check_eq("idle", idle, 1'b0);      // burst now counted
  endtask

  task automatic send_w(input entry_t t);
    int b;
    for (b = 0; b <= int'(t.len); b++) begin
      s_req.w       = {beat_data(t.addr, b, t.seed), {(`AXI_DATA_W/8){1'b1}}, b == int'(t.len)};
      s_req.w_valid = 1'b1;
      while (!s_rsp.w_ready) @(negedge ap_clk);
      if (b == 0) w_first_cyc = cyc + 1;
      sent++;
      @(negedge ap_clk);
    end
    s_req.w_valid = 1'b0;
  endtask

  task automatic recv_resp(input entry_t t);
    int b;
    int n;
    b = 0;
    n = t.wr ? 0 : int'(t.len);        // one b or len+1 r beats
    while (b <= n) begin
      @(negedge ap_clk);
      s_req.r_ready = ready_roll(3, t.stall);
      s_req.b_ready = ready_roll(4, t.stall);
      if (!t.wr && s_rsp.r_valid && s_req.r_ready) begin
        check_eq("s_rsp.r", s_rsp.r, {t.id, beat_data(t.addr, b, t.seed), 2'b00, b == n});
        b++;
        rcvd++;
      end
      if (t.wr && s_rsp.b_valid && s_req.b_ready) begin
        check_eq("s_rsp.b", s_rsp.b, {t.id, 2'b00});
        b++;
      end
    end
    check_eq("idle", idle, 1'b0);      // last response still inside
    @(negedge ap_clk);
    check_eq("idle", idle, 1'b1);
    check_eq("extra response valid", {s_rsp.r_valid, s_rsp.b_valid}, 2'b00);
  endtask

  task automatic run_entry(input int e);
    entry_t t;
    int     e0;
    t  = tbl[e];
    e0 = errors;
    @(posedge ap_clk);
    cur = e;                           // responder picks it up at the falling edge
    @(negedge ap_clk);
    fork
      send_addr(t);
      if (t.wr) send_w(t);
      recv_resp(t);
    join
    check_eq("beat count", rcvd, sent);
    $display("entry %0d %s id %0d len %0d stall %0b: %s", e, t.wr ? "write" : "read",
             t.id, t.len, t.stall, (errors == e0) ? "ok" : "errors");
  endtask

  // --------------------------------------------------
  // stimulus table and sequence
  // --------------------------------------------------
  initial begin
    int e;
    int beats;
    s_req  = '0;
    m_rsp  = '0;
    arst_n = 1'b0;
    //           wr    id     addr                    len    seed           stall
    tbl[0] = {1'b1, 4'd1, 64'h0000_0000_0000_1000, 8'd3,  32'h0000_00a5, 1'b0};
    tbl[1] = {1'b0, 4'd2, 64'h0000_0000_0000_1000, 8'd3,  32'h0000_005a, 1'b0};
    tbl[2] = {1'b1, 4'd3, 64'h0000_0001_0000_2040, 8'd7,  32'h1234_5678, 1'b1};
    tbl[3] = {1'b0, 4'd4, 64'h0000_0001_0000_2040, 8'd7,  32'hcafe_f00d, 1'b1};
    tbl[4] = {1'b0, 4'd5, 64'h0000_0000_0000_0080, 8'd0,  32'h0f0f_0f0f, 1'b0};
    tbl[5] = {1'b1, 4'd6, 64'h0000_0000_0000_3000, 8'd0,  32'h8000_0001, 1'b1};
    tbl[6] = {1'b0, 4'd7, 64'h0000_0002_0000_4000, 8'd15, 32'h00c0_ffee, 1'b1};
    tbl[7] = {1'b1, 4'd8, 64'h0000_0002_0000_4000, 8'd15, 32'h7777_1111, 1'b1};
    beats = 0;
    for (e = 0; e < N_ENTRY; e++) beats = beats + int'(tbl[e].len) + 1;
    limit = 40 * N_ENTRY + 4 * beats;
    repeat (4) begin
      @(negedge ap_clk);
      check_quiet(1'b0);
    end
    arst_n = 1'b1;
    for (e = 1; e <= `SLICE_SYNC_CYCLES + 1; e++) begin
      @(negedge ap_clk);
      check_quiet(e == `SLICE_SYNC_CYCLES + 1); // readies only after the sync delay
    end
    $display("reset sequence: %s", (errors == 0) ? "ok" : "errors");
    for (e = 0; e < N_ENTRY; e++) run_entry(e);
    $display("%0d tests, %0d checks, %0d errors", N_ENTRY + 1, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+src
src/axi_slice_pkg.sv
src/axi_skid_stage.sv
src/axi_slice_ctrl.sv
src/axi_register_slice_mid_end.sv
test/axi_slice_tb.sv

// File: Bender.yml
package:
  name: axi_register_slice_mid_end

sources:
  - include_dirs:
      - src
    files:
      - src/axi_slice_pkg.sv
      - src/axi_skid_stage.sv
      - src/axi_slice_ctrl.sv
      - src/axi_register_slice_mid_end.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/axi_slice_tb.sv
